// ==== files.f ====
source/periph_pkg.sv
source/periph_select.sv
source/read_hold.sv
source/gpio_block.sv
source/interval_timer.sv
source/gray_coder.sv
source/periph_hub.sv
test/periph_checker.sv
test/tb_periph_hub.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the peripheral hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_periph_hub -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "No pass message found in sim.log"
    exit 1
fi
exit 0

// ==== source/gpio_block.sv ====
// ##############################
// GPIO registers, function selects
// and the per-pin output mux
// ##############################

`default_nettype none

module gpio_block
    import periph_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  slot_req_t           i_req,
    input  logic [NUM_PINS-1:0] i_pins_in,
    input  pin_bytes_t          i_user_pins,
    input  pin_bytes_t          i_byte_pins,
    output slot_rsp_t           o_rsp,
    output logic [NUM_PINS-1:0] o_pins_out
);

    logic [NUM_PINS-1:0]                 gpio_out;
    logic [NUM_PINS-1:0][FUNC_SEL_W-1:0] func_sel;
    pin_bytes_t                          user_pins;
    logic                                write_req;
    logic                                sel_hit;
    logic [2:0]                          sel_idx;

    assign write_req = i_req.write_n != SIZE_IDLE;

    // Selects sit at 0x20, 0x24 .. 0x3c
    assign sel_hit = (i_req.offset & ~6'h1c) == GPIO_SEL_BASE;
    assign sel_idx = i_req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int n = 0; n < NUM_PINS; n++) begin
                func_sel[n] <= {1'b0, SLOT_GPIO};  // Every pin starts on GPIO
            end
        end else if (write_req) begin
            if (i_req.offset == GPIO_OUT_OFS) begin
                gpio_out <= i_req.wdata[NUM_PINS-1:0];
            end
            if (sel_hit) begin
                func_sel[sel_idx] <= i_req.wdata[FUNC_SEL_W-1:0];
            end
        end
    end

    // Register readback
    always_comb begin
        o_rsp.ready = 1'b1;
        o_rsp.rdata = '0;
        if (i_req.offset == GPIO_OUT_OFS) begin
            o_rsp.rdata = {24'h0, gpio_out};
        end else if (i_req.offset == GPIO_IN_OFS) begin
            o_rsp.rdata = {24'h0, i_pins_in};
        end else if (sel_hit) begin
            o_rsp.rdata = {27'h0, func_sel[sel_idx]};
        end
    end

    // GPIO's own byte replaces whatever the hub placed in its slot
    always_comb begin
        user_pins            = i_user_pins;
        user_pins[SLOT_GPIO] = gpio_out;
    end

    always_comb begin
        for (int n = 0; n < NUM_PINS; n++) begin
            if (func_sel[n][4]) begin
                o_pins_out[n] = i_byte_pins[func_sel[n][3:0]][n];
            end else begin
                o_pins_out[n] = user_pins[func_sel[n][3:0]][n];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/gray_coder.sv ====
// ##############################
// Byte peripheral with Gray-code readback
// ##############################

`default_nettype none

module gray_coder
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_write,
    input  logic [BYTE_OFS_W-1:0] i_offset,
    input  logic [7:0]            i_wdata,
    output logic [7:0]            o_rdata,
    output logic [7:0]            o_pins
);

    logic [7:0] value;
    logic [7:0] gray;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (i_write && i_offset == GRAY_VALUE_OFS) begin
            value <= i_wdata;
        end
    end

    assign gray = value ^ (value >> 1);

    always_comb begin
        case (i_offset)
            GRAY_VALUE_OFS: o_rdata = value;
            GRAY_CODE_OFS:  o_rdata = gray;
            default:        o_rdata = 8'h0;
        endcase
    end

    assign o_pins = gray;  // Pins always show the coded value

endmodule

`default_nettype wire

// ==== source/interval_timer.sv ====
// ##############################
// Interval timer on the full interface
// with sticky interrupt and toggle output
// ##############################

`default_nettype none

module interval_timer
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  slot_req_t  i_req,
    output slot_rsp_t  o_rsp,
    output logic [7:0] o_pins,
    output logic       o_interrupt
);

    logic [DATA_W-1:0] limit;
    logic [DATA_W-1:0] count;
    logic              irq;
    logic              toggle;
    logic              write_req;
    logic              running;
    logic              wrap;

    assign write_req = i_req.write_n != SIZE_IDLE;
    assign running   = limit != '0;  // Stopped while limit is zero
    assign wrap      = running && count == limit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            limit  <= '0;
            count  <= '0;
            irq    <= 1'b0;
            toggle <= 1'b0;
        end else begin
            if (wrap) begin
                count  <= '0;
                toggle <= ~toggle;
            end else if (running) begin
                count <= count + DATA_W'(1);
            end

            if (write_req) begin
                case (i_req.offset)
                    TIMER_LIMIT_OFS: begin
                        limit <= write_merge(limit, i_req.wdata, i_req.write_n);
                        count <= '0;  // Restart on a new limit
                    end
                    TIMER_COUNT_OFS:  count <= write_merge(count, i_req.wdata, i_req.write_n);
                    TIMER_STATUS_OFS: if (i_req.wdata[0]) irq <= 1'b0;
                    default: ;
                endcase
            end

            if (wrap) irq <= 1'b1;  // Event beats a clear in the same cycle
        end
    end

    always_comb begin
        o_rsp.ready = 1'b1;
        case (i_req.offset)
            TIMER_LIMIT_OFS:  o_rsp.rdata = limit;
            TIMER_COUNT_OFS:  o_rsp.rdata = count;
            TIMER_STATUS_OFS: o_rsp.rdata = {30'h0, toggle, irq};
            default:          o_rsp.rdata = '0;
        endcase
    end

    assign o_pins      = {8{toggle}};
    assign o_interrupt = irq;

endmodule

`default_nettype wire

// ==== source/periph_hub.sv ====
// ##############################
// Peripheral hub top level: decode, read hold,
// GPIO, interval timer and Gray coder
// ##############################

`default_nettype none

module periph_hub
    import periph_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  bus_req_t            i_req,
    input  logic                i_read_complete,
    input  logic [NUM_PINS-1:0] i_pins_in,
    output logic [DATA_W-1:0]   o_data,
    output logic                o_data_ready,
    output logic [NUM_PINS-1:0] o_pins_out,
    output logic [15:2]         o_user_interrupts
);

    slot_req_t             gpio_req;
    slot_req_t             timer_req;
    slot_rsp_t             gpio_rsp;
    slot_rsp_t             timer_rsp;
    slot_rsp_t             sel_rsp;
    logic                  busy;
    logic                  gray_write;
    logic [BYTE_OFS_W-1:0] gray_offset;
    logic [7:0]            gray_wdata;
    logic [7:0]            gray_rdata;
    logic [7:0]            gray_pins;
    logic [7:0]            timer_pins;
    logic                  timer_irq;
    pin_bytes_t            user_pins;
    pin_bytes_t            byte_pins;

    periph_select u_select (
        .i_req         (i_req),
        .i_busy        (busy),
        .i_gpio_rsp    (gpio_rsp),
        .i_timer_rsp   (timer_rsp),
        .i_gray_rdata  (gray_rdata),
        .o_gpio_req    (gpio_req),
        .o_timer_req   (timer_req),
        .o_gray_write  (gray_write),
        .o_gray_offset (gray_offset),
        .o_gray_wdata  (gray_wdata),
        .o_rsp         (sel_rsp)
    );

    read_hold u_read_hold (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_rsp           (sel_rsp),
        .i_read_active   (i_req.read_n != SIZE_IDLE),
        .i_write_active  (i_req.write_n != SIZE_IDLE),
        .i_read_complete (i_read_complete),
        .o_busy          (busy),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    // Unpopulated slots drive zero, GPIO fills in its own entry
    always_comb begin
        user_pins                      = '0;
        user_pins[SLOT_TIMER]          = timer_pins;
        byte_pins                      = '0;
        byte_pins[BYTE_SLOT_GRAY]      = gray_pins;
        o_user_interrupts              = '0;
        o_user_interrupts[SLOT_TIMER]  = timer_irq;  // Line 2
    end

    gpio_block u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req       (gpio_req),
        .i_pins_in   (i_pins_in),
        .i_user_pins (user_pins),
        .i_byte_pins (byte_pins),
        .o_rsp       (gpio_rsp),
        .o_pins_out  (o_pins_out)
    );

    interval_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req       (timer_req),
        .o_rsp       (timer_rsp),
        .o_pins      (timer_pins),
        .o_interrupt (timer_irq)
    );

    gray_coder u_gray (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_write  (gray_write),
        .i_offset (gray_offset),
        .i_wdata  (gray_wdata),
        .o_rdata  (gray_rdata),
        .o_pins   (gray_pins)
    );

endmodule

`default_nettype wire

// ==== source/periph_pkg.sv ====
// ##############################
// Shared peripheral hub definitions: slot numbers, field widths,
// request/response structs, size codes and the write-merge helper
// ##############################

`default_nettype none

package periph_pkg;

    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int OFS_W      = 6;    // Full-interface slot, 64 bytes
    localparam int BYTE_OFS_W = 4;    // Byte-interface slot, 16 bytes

    // Size codes used by write_n and read_n
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;
    localparam logic [1:0] SIZE_IDLE = 2'd3;

    localparam int NUM_SLOTS  = 16;   // Per slot kind
    localparam int NUM_PINS   = 8;
    localparam int FUNC_SEL_W = 5;    // Bit 4 picks the byte space

    localparam logic [3:0] SLOT_GPIO      = 4'd1;
    localparam logic [3:0] SLOT_TIMER     = 4'd2;
    localparam logic [3:0] BYTE_SLOT_GRAY = 4'd0;

    // GPIO registers
    localparam logic [OFS_W-1:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [OFS_W-1:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [OFS_W-1:0] GPIO_SEL_BASE = 6'h20;  // Pin n at base + 4n

    // Timer registers
    localparam logic [OFS_W-1:0] TIMER_LIMIT_OFS  = 6'h00;
    localparam logic [OFS_W-1:0] TIMER_COUNT_OFS  = 6'h04;
    localparam logic [OFS_W-1:0] TIMER_STATUS_OFS = 6'h08;

    // Gray coder registers
    localparam logic [BYTE_OFS_W-1:0] GRAY_VALUE_OFS = 4'h0;
    localparam logic [BYTE_OFS_W-1:0] GRAY_CODE_OFS  = 4'h1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        write_n;
        logic [1:0]        read_n;
    } bus_req_t;

    typedef struct packed {
        logic [OFS_W-1:0]  offset;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        write_n;
        logic [1:0]        read_n;
    } slot_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ready;
    } slot_rsp_t;

    // One output byte per slot
    typedef logic [NUM_SLOTS-1:0][7:0] pin_bytes_t;

    // Merge a sized write into an existing register value
    function automatic logic [DATA_W-1:0] write_merge(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [1:0]        size
    );
        logic [DATA_W-1:0] merged;
        merged = old_val;
        case (size)
            SIZE_BYTE: merged[7:0]  = new_val[7:0];
            SIZE_HALF: merged[15:0] = new_val[15:0];
            SIZE_WORD: merged       = new_val;
            default:   merged       = old_val;
        endcase
        return merged;
    endfunction

endpackage

`default_nettype wire

// ==== source/periph_select.sv ====
// ##############################
// Address decode, per-slot request masking
// and response mux
// ##############################

`default_nettype none

module periph_select
    import periph_pkg::*;
(
    input  bus_req_t              i_req,
    input  logic                  i_busy,
    input  slot_rsp_t             i_gpio_rsp,
    input  slot_rsp_t             i_timer_rsp,
    input  logic [7:0]            i_gray_rdata,
    output slot_req_t             o_gpio_req,
    output slot_req_t             o_timer_req,
    output logic                  o_gray_write,
    output logic [BYTE_OFS_W-1:0] o_gray_offset,
    output logic [7:0]            o_gray_wdata,
    output slot_rsp_t             o_rsp
);

    logic       byte_space;
    logic [3:0] full_slot;
    logic [3:0] byte_slot;
    slot_req_t  fwd_req;
    slot_req_t  idle_req;

    assign byte_space = i_req.addr[10];
    assign full_slot  = i_req.addr[9:6];
    assign byte_slot  = i_req.addr[7:4];

    always_comb begin
        fwd_req.offset  = i_req.addr[OFS_W-1:0];
        fwd_req.wdata   = i_req.wdata;
        fwd_req.write_n = i_req.write_n;
        fwd_req.read_n  = i_req.read_n | {2{i_busy}};  // No repeat read while held
        idle_req         = fwd_req;
        idle_req.write_n = SIZE_IDLE;
        idle_req.read_n  = SIZE_IDLE;
    end

    assign o_gpio_req  = (!byte_space && full_slot == SLOT_GPIO) ? fwd_req : idle_req;
    assign o_timer_req = (!byte_space && full_slot == SLOT_TIMER) ? fwd_req : idle_req;

    // Byte slots only see writes, reads are plain muxing
    assign o_gray_write  = byte_space && byte_slot == BYTE_SLOT_GRAY
                           && i_req.write_n != SIZE_IDLE;
    assign o_gray_offset = i_req.addr[BYTE_OFS_W-1:0];
    assign o_gray_wdata  = i_req.wdata[7:0];

    always_comb begin
        o_rsp.rdata = '0;  // Empty slots read zero
        o_rsp.ready = 1'b1;
        if (byte_space) begin
            if (byte_slot == BYTE_SLOT_GRAY) begin
                o_rsp.rdata = {24'h0, i_gray_rdata};
            end
        end else begin
            case (full_slot)
                SLOT_GPIO:  o_rsp = i_gpio_rsp;
                SLOT_TIMER: o_rsp = i_timer_rsp;
                default:    ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/read_hold.sv ====
// ##############################
// Registered read data with hold
// until the core completes the read
// ##############################

`default_nettype none

module read_hold
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  slot_rsp_t         i_rsp,
    input  logic              i_read_active,
    input  logic              i_write_active,
    input  logic              i_read_complete,
    output logic              o_busy,
    output logic [DATA_W-1:0] o_data,
    output logic              o_data_ready
);

    logic              hold;
    logic              ready_q;
    logic              capture;
    logic [DATA_W-1:0] data_q;

    assign capture = !hold && i_rsp.ready && i_read_active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;  // A new capture wins over completion
            ready_q <= i_read_active && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_q <= i_rsp.rdata;
    end

    assign o_busy       = hold;
    assign o_data       = data_q;
    assign o_data_ready = ready_q || i_write_active;  // Writes ack at once

endmodule

`default_nettype wire

// ==== test/periph_checker.sv ====
// ##############################
// Checker for the peripheral hub ports,
// compares with expected values, counts errors
// ##############################

`default_nettype none

module periph_checker
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [2:0]  i_kind,
    input  logic [31:0] i_value,
    input  logic [31:0] i_data,
    input  logic        i_data_ready,
    input  logic [7:0]  i_pins_out,
    input  logic [15:2] i_user_interrupts,
    output int          o_error_count,
    output int          o_check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [2:0] EXP_ACK  = 3'd1;
    localparam logic [2:0] EXP_READ = 3'd2;
    localparam logic [2:0] EXP_HOLD = 3'd3;
    localparam logic [2:0] EXP_PINS = 3'd4;
    localparam logic [2:0] EXP_IRQ  = 3'd5;

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        o_error_count++;
    endtask

    // Sample mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst_n) begin
            o_error_count = 0;
            o_check_count = 0;
        end else begin
            case (i_kind)
                EXP_ACK: begin
                    o_check_count++;
                    if (!i_data_ready) report_mismatch("no data ready during a write");
                end
                EXP_READ: begin
                    o_check_count++;
                    if (!i_data_ready) begin
                        report_mismatch("data ready missing after a read");
                    end else if (i_data !== i_value) begin
                        report_mismatch($sformatf("read data %h, expected %h",
                                                  i_data, i_value));
                    end
                end
                EXP_HOLD: begin
                    o_check_count++;
                    if (i_data !== i_value) begin
                        report_mismatch($sformatf("held data %h, expected %h",
                                                  i_data, i_value));
                    end
                end
                EXP_PINS: begin
                    o_check_count++;
                    if (i_pins_out !== i_value[7:0]) begin
                        report_mismatch($sformatf("pins %h, expected %h",
                                                  i_pins_out, i_value[7:0]));
                    end
                end
                EXP_IRQ: begin
                    o_check_count++;
                    // Only line 2 is wired, the rest stay low
                    if (i_user_interrupts !== {13'h0, i_value[0]}) begin
                        report_mismatch($sformatf("interrupts %b, expected %b",
                                                  i_user_interrupts,
                                                  {13'h0, i_value[0]}));
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== test/periph_vectors.txt ====
# op addr size data pins_in (all hex), size 0 byte 1 half 2 word 3 idle
# op 0 idle, 1 write, 2 read, 3 pin check, 4 wait irq (data = max cycles), 5 irq check
0 000 3 00000000 00
# GPIO output register, readback and input pins
1 040 2 000000a5 00
3 000 3 000000a5 00
2 040 2 000000a5 00
2 044 2 0000005a 5a
2 044 0 000000c3 c3
# Gray coder value 0c gives code 0a, then pin 3 routed to byte slot 0
1 400 0 0000000c 00
1 06c 0 00000010 00
3 000 3 000000ad 00
2 06c 2 00000010 00
2 401 0 0000000a 00
2 400 0 0000000c 00
# Timer with limit 5, interrupt within limit plus 2 cycles
1 080 2 00000005 00
4 000 3 00000007 00
5 000 3 00000001 00
1 088 2 00000001 00
5 000 3 00000000 00
1 080 2 00000000 00
# Byte write to the limit changes only bits 7..0
1 080 2 00000100 00
1 080 0 123456ab 00
2 080 2 000001ab 00
1 080 1 0000beef 00
2 080 2 0000beef 00
1 080 2 00000000 00
2 080 2 00000000 00
# Empty full and byte slots read zero
2 140 2 00000000 00
2 3c0 2 00000000 00
2 430 0 00000000 00
2 7f0 2 00000000 00
# Pins still routed after all of the above
3 000 3 000000ad 00
0 000 3 00000000 00

// ==== test/tb_periph_hub.sv ====
// ##############################
// Peripheral hub testbench: clock, reset, vector
// reader, stimulus driver and watchdog
// ##############################

`default_nettype none

module tb_periph_hub
    import periph_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_LINE = 20;

    // Expected-value kinds shared with the checker
    localparam logic [2:0] EXP_NONE = 3'd0;
    localparam logic [2:0] EXP_ACK  = 3'd1;
    localparam logic [2:0] EXP_READ = 3'd2;
    localparam logic [2:0] EXP_HOLD = 3'd3;
    localparam logic [2:0] EXP_PINS = 3'd4;
    localparam logic [2:0] EXP_IRQ  = 3'd5;

    logic        clk;
    logic        rst_n;
    bus_req_t    req;
    logic        read_complete;
    logic [7:0]  pins_in;
    logic [31:0] data;
    logic        data_ready;
    logic [7:0]  pins_out;
    logic [15:2] user_interrupts;
    logic [2:0]  exp_kind;
    logic [31:0] exp_value;
    int          error_count;
    int          check_count;
    bit          loaded;
    int          op_q[$];
    int          addr_q[$];
    int          size_q[$];
    int          data_q[$];
    int          pins_q[$];

    periph_hub i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_req             (req),
        .i_read_complete   (read_complete),
        .i_pins_in         (pins_in),
        .o_data            (data),
        .o_data_ready      (data_ready),
        .o_pins_out        (pins_out),
        .o_user_interrupts (user_interrupts)
    );

    periph_checker u_checker (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_kind            (exp_kind),
        .i_value           (exp_value),
        .i_data            (data),
        .i_data_ready      (data_ready),
        .i_pins_out        (pins_out),
        .i_user_interrupts (user_interrupts),
        .o_error_count     (error_count),
        .o_check_count     (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Lines starting with # are comments
    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        int    op;
        int    addr;
        int    size;
        int    value;
        int    pins;
        string line;
        ok = 1'b1;
        fd = $fopen("test/periph_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file test/periph_vectors.txt");
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == 8'h23) continue;
                n = $sscanf(line, "%h %h %h %h %h", op, addr, size, value, pins);
                if (n != 5 || op < 0 || op > 5) begin
                    $display("Malformed vector line: %s", line);
                    ok = 1'b0;
                end else begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    size_q.push_back(size);
                    data_q.push_back(value);
                    pins_q.push_back(pins);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        req.addr    <= '0;
        req.wdata   <= '0;
        req.write_n <= SIZE_IDLE;
        req.read_n  <= SIZE_IDLE;
        exp_kind    <= EXP_NONE;
    endtask

    task automatic run_write(input int addr, input int size, input int value);
        @(posedge clk);
        req.addr    <= addr[ADDR_W-1:0];
        req.wdata   <= value;
        req.write_n <= size[1:0];
        exp_kind    <= EXP_ACK;  // Ack in the write cycle itself
        exp_value   <= '0;
        @(posedge clk);
        drive_idle();
    endtask

    task automatic run_read(input int addr, input int size, input int value, input int pins);
        @(posedge clk);
        req.addr   <= addr[ADDR_W-1:0];
        req.read_n <= size[1:0];
        pins_in    <= pins[7:0];
        @(posedge clk);
        drive_idle();
        exp_kind  <= EXP_READ;
        exp_value <= value;
        @(posedge clk);
        req.addr   <= addr[ADDR_W-1:0];  // Repeat read while the result is held
        req.read_n <= size[1:0];
        exp_kind   <= EXP_HOLD;
        pins_in    <= ~pins[7:0];  // Data must not follow the pins now
        @(posedge clk);
        drive_idle();
        exp_kind      <= EXP_HOLD;
        read_complete <= 1'b1;
        @(posedge clk);
        exp_kind      <= EXP_NONE;
        read_complete <= 1'b0;
    endtask

    task automatic expect_level(input logic [2:0] kind, input int value);
        @(posedge clk);
        exp_kind  <= kind;
        exp_value <= value;
        @(posedge clk);
        exp_kind <= EXP_NONE;
    endtask

    task automatic wait_interrupt(input int max_cycles);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < max_cycles) begin
            if (waited == max_cycles - 1) begin
                exp_kind  <= EXP_IRQ;  // Last allowed cycle
                exp_value <= 32'd1;
            end
            @(negedge clk);
            waited++;
            seen = user_interrupts[2];
            if (!seen && waited < max_cycles) @(posedge clk);
        end
        exp_kind <= EXP_NONE;
    endtask

    initial begin
        rst_n         = 1'b0;
        req           = '{addr: '0, wdata: '0, write_n: SIZE_IDLE, read_n: SIZE_IDLE};
        read_complete = 1'b0;
        pins_in       = '0;
        exp_kind      = EXP_NONE;
        exp_value     = '0;
        load_vectors(loaded);
        if (!loaded) begin
            $display("Some tests failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            foreach (op_q[i]) begin
                case (op_q[i])
                    0: expect_level(EXP_NONE, 0);
                    1: run_write(addr_q[i], size_q[i], data_q[i]);
                    2: run_read(addr_q[i], size_q[i], data_q[i], pins_q[i]);
                    3: expect_level(EXP_PINS, data_q[i]);
                    4: wait_interrupt(data_q[i]);
                    5: expect_level(EXP_IRQ, data_q[i]);
                    default: ;
                endcase
            end
            repeat (2) @(posedge clk);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of vector lines
    initial begin
        wait (loaded);
        #((RESET_CYCLES + CYCLES_PER_LINE * op_q.size()) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
